//--- audio_pkg.sv
`default_nettype none

package audio_pkg;

   localparam int PHASE_WIDTH = 20;   // Phase accumulator, one full cycle per wrap
   localparam int TRI_WIDTH   = 16;   // Raw triangle value
   localparam int VOICE_WIDTH = 17;   // Fundamental plus harmonic of one voice
   localparam int MIX_WIDTH   = 18;   // Sum of the three voices

   // Harmonic weight n scales the second harmonic down by n+1 bits
   typedef logic [1:0] weight_t;

   // Signed triangle built from the top phase bits.
   // Zero at phase 0, peak at a quarter turn, trough at three quarters.
   function automatic logic signed [TRI_WIDTH-1:0] triangle_of(
      input logic [PHASE_WIDTH-1:0] phase
   );
      logic [TRI_WIDTH-2:0] ramp;
      logic signed [TRI_WIDTH-1:0] rising;
      logic signed [TRI_WIDTH-1:0] falling;
      ramp    = phase[PHASE_WIDTH-3 -: TRI_WIDTH-1];
      rising  = signed'({1'b0, ramp});
      falling = signed'({1'b0, ~ramp});   // Full scale minus ramp
      case (phase[PHASE_WIDTH-1 -: 2])
         2'd0:    return rising;
         2'd1:    return falling;
         2'd2:    return -rising;
         default: return -falling;
      endcase
   endfunction

endpackage

`default_nettype wire

//--- music_pkg.sv
`default_nettype none

package music_pkg;
   import audio_pkg::*;

   localparam int NOTE_WIDTH = 6;   // Note numbers and durations in beats
   localparam logic [NOTE_WIDTH-1:0] REST_NOTE = '0;
   localparam int NOTES_PER_OCTAVE = 12;

   // Phase steps of the lowest octave at 48 kHz sampling, note 1 is A at 55 Hz
   function automatic logic [PHASE_WIDTH-1:0] base_step(input int semitone);
      case (semitone)
         0:       return PHASE_WIDTH'(1201);
         1:       return PHASE_WIDTH'(1273);
         2:       return PHASE_WIDTH'(1349);
         3:       return PHASE_WIDTH'(1429);
         4:       return PHASE_WIDTH'(1514);
         5:       return PHASE_WIDTH'(1604);
         6:       return PHASE_WIDTH'(1699);
         7:       return PHASE_WIDTH'(1800);
         8:       return PHASE_WIDTH'(1907);
         9:       return PHASE_WIDTH'(2021);
         10:      return PHASE_WIDTH'(2141);
         default: return PHASE_WIDTH'(2268);
      endcase
   endfunction

   // Equal-tempered step for each of the 64 note numbers.
   // Every twelve notes up doubles the step.
   function automatic logic [PHASE_WIDTH-1:0] phase_step_for(
      input logic [NOTE_WIDTH-1:0] note
   );
      int index;
      if (note == REST_NOTE)
         return '0;   // Rest holds the phase still
      index = int'(note) - 1;
      return base_step(index % NOTES_PER_OCTAVE) << (index / NOTES_PER_OCTAVE);
   endfunction

endpackage

`default_nettype wire

//--- beat_generator.sv
`timescale 1ns/1ns
`default_nettype none

module beat_generator #(
   parameter int BEAT_DIVIDE = 1_000_000   // Clocks per beat
) (
   input  logic clk,
   input  logic reset,
   output logic beat
);

   localparam int COUNT_WIDTH = (BEAT_DIVIDE > 2) ? $clog2(BEAT_DIVIDE) : 1;

   logic [COUNT_WIDTH-1:0] count;

   // Counts down from BEAT_DIVIDE-1, one beat per wrap
   always_ff @(posedge clk) begin
      if (reset) begin
         count <= COUNT_WIDTH'(BEAT_DIVIDE - 1);
         beat  <= 1'b0;
      end else if (count == '0) begin
         count <= COUNT_WIDTH'(BEAT_DIVIDE - 1);   // Reload
         beat  <= 1'b1;
      end else begin
         count <= count - 1'b1;
         beat  <= 1'b0;
      end
   end

   // Beat is a strobe and never spans two clocks
   beat_single_cycle: assert property (
      @(posedge clk) disable iff (reset) beat |=> !beat
   ) else $error("beat held high for two cycles");

endmodule

`default_nettype wire

//--- note_player.sv
`timescale 1ns/1ns
`default_nettype none

module note_player
   import music_pkg::*;
   import audio_pkg::*;
(
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          play_enable,
   input  logic                          generate_next_sample,
   input  logic                          load_new_note,
   input  logic                          note_done,
   input  weight_t                       weight,
   input  logic [NOTE_WIDTH-1:0]         note_to_load,
   output logic                          harmonic_ready,
   output logic signed [VOICE_WIDTH-1:0] harmonic_out
);

   logic [PHASE_WIDTH-1:0] phase;
   logic [PHASE_WIDTH-1:0] step;
   logic [PHASE_WIDTH-1:0] next_phase;
   logic signed [TRI_WIDTH-1:0] fundamental;
   logic signed [TRI_WIDTH-1:0] second;
   logic signed [TRI_WIDTH-1:0] second_scaled;
   logic signed [VOICE_WIDTH-1:0] voice_value;
   logic load;
   logic serve;

   assign load = load_new_note && play_enable;
   // A request that lands on the ready pulse is not served
   assign serve = generate_next_sample && !harmonic_ready;
   assign next_phase = phase + step;

   // Fundamental plus second harmonic at twice the phase
   always_comb begin
      fundamental   = triangle_of(next_phase);
      second        = triangle_of({next_phase[PHASE_WIDTH-2:0], 1'b0});
      second_scaled = second >>> (3'(weight) + 3'd1);
      voice_value   = VOICE_WIDTH'(fundamental) + VOICE_WIDTH'(second_scaled);
   end

   always_ff @(posedge clk) begin
      if (load)
         step <= phase_step_for(note_to_load);   // Pitch of the new note
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         phase          <= '0;
         harmonic_out   <= '0;
         harmonic_ready <= 1'b0;
      end else begin
         harmonic_ready <= serve;

         // New note starts at phase zero, a silent voice stays there
         if (load || note_done)
            phase <= '0;
         else if (serve)
            phase <= next_phase;

         if (note_done)
            harmonic_out <= '0;
         else if (serve)
            harmonic_out <= voice_value;
      end
   end

   // A served request gives exactly one ready cycle
   ready_one_cycle: assert property (
      @(posedge clk) disable iff (reset)
      serve |=> harmonic_ready ##1 !harmonic_ready
   ) else $error("harmonic_ready not a single pulse after a request");

endmodule

`default_nettype wire

//--- harm_chord_player.sv
`timescale 1ns/1ns
`default_nettype none

module harm_chord_player
   import music_pkg::*;
   import audio_pkg::*;
(
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        play_enable,          // Counts and loads only when high
   input  logic                        load_new_note,        // Strobe with a new note
   input  logic                        activate,             // Next load goes to the window
   input  logic                        beat,
   input  logic                        generate_next_sample, // Codec wants a sample
   input  logic [NOTE_WIDTH-1:0]       note_to_load,
   input  logic [NOTE_WIDTH-1:0]       duration,             // In beats
   input  weight_t                     weight,
   output logic                        note_done,
   output logic                        activate_done,
   output logic                        sample_ready,
   output logic signed [MIX_WIDTH-1:0] final_sample
);

   logic [NOTE_WIDTH-1:0] voice_count [3];
   logic [NOTE_WIDTH-1:0] window_count;   // Chord window timer
   logic [2:0] voice_free;
   logic [2:0] voice_load;
   logic [2:0] voice_ready;
   logic signed [VOICE_WIDTH-1:0] voice_out [3];
   logic window_run;
   logic load_window;

   always_comb begin
      for (int i = 0; i < 3; i++) begin
         voice_free[i] = (voice_count[i] == '0);
      end
   end

   assign window_run  = (window_count != '0);
   assign load_window = load_new_note && activate && !window_run;

   // Lowest free voice takes the new note
   always_comb begin
      voice_load = '0;
      if (load_new_note && !load_window) begin
         if (voice_free[0])
            voice_load[0] = 1'b1;
         else if (voice_free[1])
            voice_load[1] = 1'b1;
         else if (voice_free[2])
            voice_load[2] = 1'b1;   // Otherwise the note is dropped
      end
   end

   // Everything freezes while play_enable is low
   always_ff @(posedge clk) begin
      if (reset) begin
         window_count <= '0;
         for (int i = 0; i < 3; i++) begin
            voice_count[i] <= '0;
         end
      end else if (play_enable) begin
         if (load_window)
            window_count <= duration;
         else if (beat && window_run)
            window_count <= window_count - 1'b1;

         // Voices only age inside a running window
         for (int i = 0; i < 3; i++) begin
            if (voice_load[i])
               voice_count[i] <= duration;
            else if (beat && window_run && !voice_free[i])
               voice_count[i] <= voice_count[i] - 1'b1;
         end
      end
   end

   note_player np1 (
      .clk                  (clk),
      .reset                (reset),
      .play_enable          (play_enable),
      .generate_next_sample (generate_next_sample),
      .load_new_note        (voice_load[0]),
      .note_done            (voice_free[0]),
      .weight               (weight),
      .note_to_load         (note_to_load),
      .harmonic_ready       (voice_ready[0]),
      .harmonic_out         (voice_out[0])
   );

   note_player np2 (
      .clk                  (clk),
      .reset                (reset),
      .play_enable          (play_enable),
      .generate_next_sample (generate_next_sample),
      .load_new_note        (voice_load[1]),
      .note_done            (voice_free[1]),
      .weight               (weight),
      .note_to_load         (note_to_load),
      .harmonic_ready       (voice_ready[1]),
      .harmonic_out         (voice_out[1])
   );

   note_player np3 (
      .clk                  (clk),
      .reset                (reset),
      .play_enable          (play_enable),
      .generate_next_sample (generate_next_sample),
      .load_new_note        (voice_load[2]),
      .note_done            (voice_free[2]),
      .weight               (weight),
      .note_to_load         (note_to_load),
      .harmonic_ready       (voice_ready[2]),
      .harmonic_out         (voice_out[2])
   );

   // Mix of the three registered voice samples
   assign final_sample = MIX_WIDTH'(voice_out[0]) + MIX_WIDTH'(voice_out[1])
                       + MIX_WIDTH'(voice_out[2]);
   assign sample_ready  = |voice_ready;
   assign activate_done = !window_run;
   assign note_done     = |voice_free || !window_run;

   voice_load_onehot: assert property (
      @(posedge clk) disable iff (reset) $onehot0(voice_load)
   ) else $error("more than one voice loaded in a cycle");

endmodule

`default_nettype wire

//--- chord_synth_top.sv
`timescale 1ns/1ns
`default_nettype none

module chord_synth_top
   import music_pkg::*;
   import audio_pkg::*;
#(
   parameter int BEAT_DIVIDE = 1_000_000   // 48 Hz beat from a 48 MHz clock
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        play_enable,
   input  logic [NOTE_WIDTH-1:0]       note_to_load,
   input  logic [NOTE_WIDTH-1:0]       duration,
   input  logic                        load_new_note,
   input  logic                        activate,
   input  logic                        generate_next_sample,
   input  weight_t                     weight,
   output logic signed [MIX_WIDTH-1:0] final_sample,
   output logic                        sample_ready,
   output logic                        note_done,
   output logic                        activate_done
);

   logic beat;

   beat_generator #(
      .BEAT_DIVIDE (BEAT_DIVIDE)
   ) beat_gen (
      .clk   (clk),
      .reset (reset),
      .beat  (beat)
   );

   harm_chord_player chord_player (
      .clk                  (clk),
      .reset                (reset),
      .play_enable          (play_enable),
      .load_new_note        (load_new_note),
      .activate             (activate),
      .beat                 (beat),
      .generate_next_sample (generate_next_sample),
      .note_to_load         (note_to_load),
      .duration             (duration),
      .weight               (weight),
      .note_done            (note_done),
      .activate_done        (activate_done),
      .sample_ready         (sample_ready),
      .final_sample         (final_sample)
   );

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
   parameter int PERIOD       = 20,
   parameter int RESET_CYCLES = 16
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Reset covers the first RESET_CYCLES rising edges and drops on a falling edge
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

`default_nettype wire

//--- tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_checker
   import music_pkg::*;
   import audio_pkg::*;
#(
   parameter int BEAT_DIVIDE = 8
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        play_enable,
   input  logic [NOTE_WIDTH-1:0]       note_to_load,
   input  logic [NOTE_WIDTH-1:0]       duration,
   input  logic                        load_new_note,
   input  logic                        activate,
   input  logic                        generate_next_sample,
   input  weight_t                     weight,
   input  logic signed [MIX_WIDTH-1:0] final_sample,
   input  logic                        sample_ready,
   input  logic                        note_done,
   input  logic                        activate_done,
   output int                          errors,
   output int                          cycles,
   output int                          samples
);

   int edges_seen;   // Rising edges since reset fell
   int window;
   int count [3];
   int voice [3];
   logic [PHASE_WIDTH-1:0] step [3];
   logic [PHASE_WIDTH-1:0] phase [3];
   logic ready;
   logic started = 1'b0;
   int error_count = 0;
   int cycle_count = 0;
   int sample_count = 0;

   assign errors  = error_count;
   assign cycles  = cycle_count;
   assign samples = sample_count;

   // Fundamental plus second harmonic scaled down by weight+1 bits
   function automatic int expected_voice(input logic [PHASE_WIDTH-1:0] p, input weight_t w);
      int fund;
      int harm;
      fund = int'(triangle_of(p));
      harm = int'(triangle_of(p << 1)) >>> (int'(w) + 1);
      return fund + harm;
   endfunction

   task automatic check_value(input string name, input int expected, input int actual);
      if (actual != expected) begin
         error_count++;
         $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
      end
   endtask

   // Reference model, steps on the same edges as the DUT
   always @(posedge clk) begin
      logic beat_now;
      logic serve;
      logic load_window;
      int slot;
      if (reset) begin
         started    = 1'b1;
         edges_seen = 0;
         window     = 0;
         ready      = 1'b0;
         for (int i = 0; i < 3; i++) begin
            count[i] = 0;
            voice[i] = 0;
            step[i]  = '0;
            phase[i] = '0;
         end
      end else begin
         // First beat BEAT_DIVIDE clocks after reset, then every BEAT_DIVIDE
         beat_now    = (edges_seen > 0) && (edges_seen % BEAT_DIVIDE == 0);
         edges_seen  = edges_seen + 1;
         serve       = generate_next_sample && !ready;
         load_window = 1'b0;
         slot        = -1;
         if (play_enable && load_new_note) begin
            if (activate && window == 0)
               load_window = 1'b1;
            else
               for (int i = 2; i >= 0; i--)
                  if (count[i] == 0)
                     slot = i;   // Lowest free voice wins
         end
         for (int i = 0; i < 3; i++) begin
            if (slot == i)
               step[i] = phase_step_for(note_to_load);
            if (count[i] == 0) begin
               phase[i] = '0;   // Done voice is silent
               voice[i] = 0;
            end else if (serve) begin
               phase[i] = phase[i] + step[i];
               voice[i] = expected_voice(phase[i], weight);
            end
         end
         ready = serve;
         if (serve)
            sample_count++;
         if (play_enable) begin
            for (int i = 0; i < 3; i++) begin
               if (slot == i)
                  count[i] = int'(duration);
               else if (beat_now && window != 0 && count[i] != 0)
                  count[i] = count[i] - 1;
            end
            if (load_window)
               window = int'(duration);
            else if (beat_now && window != 0)
               window = window - 1;
         end
      end
   end

   // Outputs are all registered, so the falling edge sees them settled
   always @(negedge clk) begin
      if (started) begin
         cycle_count++;
         if ($isunknown({final_sample, sample_ready, note_done, activate_done})) begin
            error_count++;
            $display("A DUT output is unknown at t=%0t", $time);
         end
         check_value("final_sample", voice[0] + voice[1] + voice[2], int'(final_sample));
         check_value("sample_ready", int'(ready), int'(sample_ready));
         check_value("note_done",
                     int'(count[0] == 0 || count[1] == 0 || count[2] == 0 || window == 0),
                     int'(note_done));
         check_value("activate_done", int'(window == 0), int'(activate_done));
      end
   end

endmodule

`default_nettype wire

//--- tb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top
   import music_pkg::*;
   import audio_pkg::*;
();

   localparam int BEAT_DIVIDE  = 8;
   localparam int CLOCK_PERIOD = 20;
   localparam int RESET_CYCLES = 16;
   localparam int MAX_GAP      = 3;   // Pause after a request, 0 to 3 clocks
   localparam int TAIL_CYCLES  = 10;
   localparam int NUM_STEPS    = 14;

   typedef struct packed {
      logic [NOTE_WIDTH-1:0] note;
      logic [NOTE_WIDTH-1:0] duration;   // Zero means no load strobe
      logic                  activate;
      logic                  play_enable;
      logic [1:0]            weight;
      logic [7:0]            requests;
      logic [7:0]            idle;
   } step_t;

   // note, duration, activate, play_enable, weight, requests, idle
   localparam step_t STEPS [NUM_STEPS] = '{
      '{6'd0,  6'd0,  1'b0, 1'b1, 2'd0, 8'd3, 8'd4},    // Silence after reset
      '{6'd0,  6'd30, 1'b1, 1'b1, 2'd0, 8'd0, 8'd2},    // Open the chord window
      '{6'd10, 6'd10, 1'b0, 1'b1, 2'd0, 8'd6, 8'd0},
      '{6'd22, 6'd14, 1'b0, 1'b1, 2'd1, 8'd6, 8'd0},
      '{6'd37, 6'd6,  1'b0, 1'b1, 2'd2, 8'd6, 8'd0},
      '{6'd45, 6'd2,  1'b1, 1'b1, 2'd3, 8'd6, 8'd0},    // All slots busy
      '{6'd50, 6'd9,  1'b0, 1'b0, 2'd3, 8'd4, 8'd24},   // Paused
      '{6'd0,  6'd0,  1'b0, 1'b1, 2'd1, 8'd8, 8'd80},   // Voices run out
      '{6'd0,  6'd4,  1'b0, 1'b1, 2'd0, 8'd4, 8'd4},    // Rest note
      '{6'd12, 6'd3,  1'b0, 1'b1, 2'd3, 8'd6, 8'd0},
      '{6'd30, 6'd2,  1'b0, 1'b1, 2'd2, 8'd5, 8'd40},
      '{6'd0,  6'd0,  1'b0, 1'b1, 2'd0, 8'd3, 8'd80},   // Window closes, voices freeze
      '{6'd0,  6'd5,  1'b1, 1'b1, 2'd1, 8'd2, 8'd60},
      '{6'd25, 6'd2,  1'b0, 1'b1, 2'd1, 8'd6, 8'd30}    // Reload a finished voice
   };

   logic clk;
   logic reset;
   logic play_enable;
   logic [NOTE_WIDTH-1:0] note_to_load;
   logic [NOTE_WIDTH-1:0] duration;
   logic load_new_note;
   logic activate;
   logic generate_next_sample;
   weight_t weight;
   logic signed [MIX_WIDTH-1:0] final_sample;
   logic sample_ready;
   logic note_done;
   logic activate_done;
   int errors;
   int cycles;
   int samples;
   int seed;

   tb_clock #(.PERIOD(CLOCK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock_gen (
      .clk   (clk),
      .reset (reset)
   );

   chord_synth_top #(.BEAT_DIVIDE(BEAT_DIVIDE)) dut (
      .clk(clk), .reset(reset), .play_enable(play_enable), .note_to_load(note_to_load),
      .duration(duration), .load_new_note(load_new_note), .activate(activate),
      .generate_next_sample(generate_next_sample), .weight(weight),
      .final_sample(final_sample), .sample_ready(sample_ready), .note_done(note_done),
      .activate_done(activate_done)
   );

   tb_checker #(.BEAT_DIVIDE(BEAT_DIVIDE)) scoreboard (
      .clk(clk), .reset(reset), .play_enable(play_enable), .note_to_load(note_to_load),
      .duration(duration), .load_new_note(load_new_note), .activate(activate),
      .generate_next_sample(generate_next_sample), .weight(weight),
      .final_sample(final_sample), .sample_ready(sample_ready), .note_done(note_done),
      .activate_done(activate_done), .errors(errors), .cycles(cycles), .samples(samples)
   );

   function automatic int run_time_ns();
      int total;
      total = RESET_CYCLES + TAIL_CYCLES;
      for (int s = 0; s < NUM_STEPS; s++)
         total += 2 + int'(STEPS[s].requests) * (1 + MAX_GAP) + int'(STEPS[s].idle);
      return total * CLOCK_PERIOD * 12 / 10;   // 20 percent margin
   endfunction

   task automatic apply_step(input step_t st);
      int gap;
      @(negedge clk);
      play_enable   = st.play_enable;
      activate      = st.activate;
      weight        = st.weight;
      note_to_load  = st.note;
      duration      = st.duration;
      load_new_note = (st.duration != '0);
      @(negedge clk);
      load_new_note = 1'b0;
      for (int r = 0; r < int'(st.requests); r++) begin
         generate_next_sample = 1'b1;
         @(negedge clk);
         generate_next_sample = 1'b0;
         gap = $random(seed) & MAX_GAP;   // Zero gap gives a back-to-back request
         repeat (gap) @(negedge clk);
      end
      repeat (int'(st.idle)) @(negedge clk);
   endtask

   initial begin
      seed                 = 47;
      play_enable          = 1'b0;
      note_to_load         = '0;
      duration             = '0;
      load_new_note        = 1'b0;
      activate             = 1'b0;
      generate_next_sample = 1'b0;
      weight               = '0;
      @(posedge clk);
      wait (!reset);
      for (int s = 0; s < NUM_STEPS; s++)
         apply_step(STEPS[s]);
      repeat (TAIL_CYCLES) @(negedge clk);
      $display("Run done: %0d errors in %0d cycles, %0d samples", errors, cycles, samples);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

   // Watchdog
   initial begin
      int limit_ns;
      limit_ns = run_time_ns();
      #(limit_ns);
      $display("Timeout: the run did not finish within %0d ns", limit_ns);
      $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
audio_pkg.sv
music_pkg.sv
beat_generator.sv
note_player.sv
harm_chord_player.sv
chord_synth_top.sv
tb_clock.sv
tb_checker.sv
tb_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_top
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass message shows up on a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
